// File: logic/cmat_consts.svh
`ifndef CMAT_CONSTS_SVH
`define CMAT_CONSTS_SVH

// order of the square matrices A, B and C
`define CMAT_N 4

// elements held per matrix region
`define CMAT_WORDS (`CMAT_N * `CMAT_N)

// word bases of the three regions inside the shared store
`define CMAT_A_BASE 0
`define CMAT_B_BASE (`CMAT_WORDS)
`define CMAT_C_BASE (2 * `CMAT_WORDS)

// byte offsets of the register window, right after the C region
`define CMAT_CTRL_OFS (3 * `CMAT_WORDS * 4)
`define CMAT_STAT_OFS (`CMAT_CTRL_OFS + 4)

`endif

// File: logic/cmat_pkg.sv
`default_nettype none

package cmat_pkg;

    // one signed component and one complex element (real high, imaginary low)
    typedef logic signed [15:0] comp_t;
    typedef logic [31:0] cplx_t;

    // accumulator component wide enough for a full 16x16 product
    typedef logic signed [31:0] cacc_t;

    // word address into the shared store
    typedef logic [5:0] maddr_t;

    // store request as driven by either requester
    typedef struct packed {
        logic   valid;
        logic   we;
        maddr_t addr;
        cplx_t  wdata;
    } mem_req_t;

    // read data steered back toward one requester
    typedef struct packed {
        logic  rvalid;
        cplx_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [2:0] {IDLE, RD_A, RD_B, ACC, WR_C, FINISH} eng_state_t;

endpackage

`default_nettype wire

// File: logic/cmat_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmat_consts.svh"

module cmat_store (
    input  logic               clk,
    input  cmat_pkg::mem_req_t req,
    output cmat_pkg::cplx_t    rdata
);

    import cmat_pkg::*;

    // regions A, B and C back to back, one complex element per word
    cplx_t mem [0:3*`CMAT_WORDS-1];

    // single port, so a cycle carries either a read or a write
    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // the read is registered and shows up one cycle after the request
    // the old word is returned on a write cycle, which no requester looks at
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/cmat_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cmat_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  cmat_pkg::mem_req_t host_req,
    input  cmat_pkg::mem_req_t eng_req,
    output logic               host_gnt,
    output logic               eng_gnt,
    output cmat_pkg::mem_rsp_t host_rsp,
    output cmat_pkg::mem_rsp_t eng_rsp,
    output cmat_pkg::mem_req_t store_req,
    input  cmat_pkg::cplx_t    store_rdata
);

    import cmat_pkg::*;

    // which requester owns the read that is in the store this cycle
    logic host_rd_q;
    logic eng_rd_q;

    // host accesses are short, so the host always wins
    assign host_gnt = host_req.valid;
    assign eng_gnt  = eng_req.valid && !host_req.valid;

    // exactly one request reaches the store, or an idle one
    always_comb begin
        if (host_gnt) begin
            store_req = host_req;
        end else if (eng_gnt) begin
            store_req = eng_req;
        end else begin
            store_req = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            host_rd_q <= 1'b0;
            eng_rd_q  <= 1'b0;
        end else begin
            host_rd_q <= host_gnt && !host_req.we;
            eng_rd_q  <= eng_gnt && !eng_req.we;
        end
    end

    // data goes to both, but only the granted reader sees rvalid
    assign host_rsp = '{rvalid: host_rd_q, rdata: store_rdata};
    assign eng_rsp  = '{rvalid: eng_rd_q, rdata: store_rdata};

    gnt_onehot: assert property (@(posedge clk) disable iff (rst)
        !(host_gnt && eng_gnt));

    gnt_needs_req: assert property (@(posedge clk) disable iff (rst)
        (host_gnt |-> host_req.valid) and (eng_gnt |-> eng_req.valid));

    // a stalled engine request stays put until the store takes it
    eng_hold: assert property (@(posedge clk) disable iff (rst)
        (eng_req.valid && !eng_gnt) |=> (eng_req.valid && $stable(eng_req)));

endmodule

`default_nettype wire

// File: logic/cmat_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmat_consts.svh"

module cmat_apb_regs (
    input  logic               clk,
    input  logic               rst,
    input  cmat_pkg::apb_req_t apb,
    output cmat_pkg::apb_rsp_t apb_out,
    output cmat_pkg::mem_req_t mem_req,
    input  logic               mem_gnt,
    input  cmat_pkg::mem_rsp_t mem_rsp,
    output logic               start,
    input  logic               busy,
    input  logic               finish,
    output logic               irq
);

    import cmat_pkg::*;

    logic   access;
    maddr_t word;
    logic   mat_hit;
    logic   ctrl_hit;
    logic   stat_hit;
    logic   err_hit;
    // set once a matrix read has been granted and the data is pending
    logic   issued;
    logic   done_q;
    logic   start_q;

    assign access   = apb.psel && apb.penable;
    // byte address to word index, the two low bits are ignored
    assign word     = apb.paddr[7:2];
    assign mat_hit  = word < (`CMAT_C_BASE + `CMAT_WORDS);
    assign ctrl_hit = word == (`CMAT_CTRL_OFS >> 2);
    assign stat_hit = word == (`CMAT_STAT_OFS >> 2);
    assign err_hit  = word > (`CMAT_STAT_OFS >> 2);

    // matrix words go to the store, the request holds until granted
    always_comb begin
        mem_req       = '0;
        mem_req.valid = access && mat_hit && !issued;
        mem_req.we    = apb.pwrite;
        mem_req.addr  = word;
        mem_req.wdata = apb.pwdata;
    end

    // registers complete at once, writes on grant, reads when data returns
    always_comb begin
        apb_out         = '0;
        apb_out.pslverr = access && err_hit;
        if (access) begin
            if (ctrl_hit || stat_hit || err_hit) begin
                apb_out.pready = 1'b1;
            end else if (apb.pwrite) begin
                apb_out.pready = mem_gnt;
            end else begin
                apb_out.pready = mem_rsp.rvalid;
            end
        end
        if (stat_hit) begin
            apb_out.prdata = {30'd0, done_q, busy};
        end else if (mat_hit) begin
            apb_out.prdata = mem_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issued  <= 1'b0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (apb_out.pready) begin
                issued <= 1'b0;
            end else if (mem_gnt) begin
                issued <= 1'b1;
            end
            // a start request while the engine runs is dropped
            start_q <= access && apb.pwrite && ctrl_hit && apb.pwdata[0] && !busy;
            // done is sticky until the next job starts
            if (start_q) begin
                done_q <= 1'b0;
            end else if (finish) begin
                done_q <= 1'b1;
            end
        end
    end

    assign start = start_q;
    assign irq   = done_q;

    // the engine never sees a start while it is still working
    start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

`default_nettype wire

// File: logic/vec_mult_acc.sv
`timescale 1ns/10ps
`default_nettype none

module vec_mult_acc (
    input  logic            clk,
    input  logic            rst,
    input  logic            clear,
    input  logic            term_valid,
    input  cmat_pkg::cplx_t a,
    input  cmat_pkg::cplx_t b,
    output cmat_pkg::cacc_t acc_re,
    output cmat_pkg::cacc_t acc_im,
    output logic            acc_valid
);

    import cmat_pkg::*;

    comp_t a_re;
    comp_t a_im;
    comp_t b_re;
    comp_t b_im;
    // stage one products, named after the components multiplied
    cacc_t p_rr;
    cacc_t p_ii;
    cacc_t p_ri;
    cacc_t p_ir;
    logic  s1_valid;
    // at least one term has landed since the last clear
    logic  dirty;

    assign a_re = a[31:16];
    assign a_im = a[15:0];
    assign b_re = b[31:16];
    assign b_im = b[15:0];

    always_ff @(posedge clk) begin
        p_rr <= a_re * b_re;
        p_ii <= a_im * b_im;
        p_ri <= a_re * b_im;
        p_ir <= a_im * b_re;
    end

    // stage two folds one term into each running sum, wrapping at 32 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            dirty    <= 1'b0;
            acc_re   <= '0;
            acc_im   <= '0;
        end else begin
            s1_valid <= term_valid;
            if (clear) begin
                dirty  <= 1'b0;
                acc_re <= '0;
                acc_im <= '0;
            end else if (s1_valid) begin
                dirty  <= 1'b1;
                acc_re <= acc_re + p_rr - p_ii;
                acc_im <= acc_im + p_ri + p_ir;
            end
        end
    end

    // sums are final once nothing is entering or sitting in the pipeline
    assign acc_valid = dirty && !s1_valid && !term_valid;

endmodule

`default_nettype wire

// File: logic/mat_mult_complex.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmat_consts.svh"

module mat_mult_complex (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output logic               busy,
    output logic               finish,
    output cmat_pkg::mem_req_t mem_req,
    input  logic               mem_gnt,
    input  cmat_pkg::mem_rsp_t mem_rsp
);

    import cmat_pkg::*;

    eng_state_t state;
    // row of A, column of B and the running inner index
    logic [$clog2(`CMAT_N)-1:0] i;
    logic [$clog2(`CMAT_N)-1:0] j;
    logic [$clog2(`CMAT_N)-1:0] k;
    logic  clear;
    // the read returning this cycle is a B word
    logic  b_pend;
    cplx_t a_q;
    logic  term_valid;
    cacc_t acc_re;
    cacc_t acc_im;
    logic  acc_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            i      <= '0;
            j      <= '0;
            k      <= '0;
            clear  <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            clear  <= 1'b0;
            b_pend <= (state == RD_B) && mem_gnt;
            case (state)
                IDLE: begin
                    if (start) begin
                        i     <= '0;
                        j     <= '0;
                        k     <= '0;
                        clear <= 1'b1;
                        state <= RD_A;
                    end
                end
                RD_A: begin
                    if (mem_gnt) state <= RD_B;
                end
                RD_B: begin
                    if (mem_gnt) begin
                        // the last B read of the element sends us to drain
                        k     <= (k == `CMAT_N - 1) ? '0 : k + 1'b1;
                        state <= (k == `CMAT_N - 1) ? ACC : RD_A;
                    end
                end
                ACC: begin
                    if (acc_valid) state <= WR_C;
                end
                WR_C: begin
                    if (mem_gnt) begin
                        j     <= (j == `CMAT_N - 1) ? '0 : j + 1'b1;
                        clear <= 1'b1;
                        state <= RD_A;
                        if (j == `CMAT_N - 1) begin
                            i <= i + 1'b1;
                            if (i == `CMAT_N - 1) state <= FINISH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A arrives first and waits here until its B partner returns
    always_ff @(posedge clk) begin
        if (mem_rsp.rvalid && !b_pend) a_q <= mem_rsp.rdata;
    end

    assign term_valid = mem_rsp.rvalid && b_pend;

    vec_mult_acc u_mac (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .term_valid (term_valid),
        .a          (a_q),
        .b          (mem_rsp.rdata),
        .acc_re     (acc_re),
        .acc_im     (acc_im),
        .acc_valid  (acc_valid)
    );

    // each state that touches the store holds its request until granted
    always_comb begin
        mem_req = '0;
        case (state)
            RD_A: begin
                mem_req.valid = 1'b1;
                mem_req.addr  = maddr_t'(`CMAT_A_BASE + i * `CMAT_N + k);
            end
            RD_B: begin
                mem_req.valid = 1'b1;
                mem_req.addr  = maddr_t'(`CMAT_B_BASE + k * `CMAT_N + j);
            end
            WR_C: begin
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = maddr_t'(`CMAT_C_BASE + i * `CMAT_N + j);
                // only the low half of each sum is kept
                mem_req.wdata = {acc_re[15:0], acc_im[15:0]};
            end
            default: mem_req = '0;
        endcase
    end

    assign busy   = (state != IDLE);
    assign finish = (state == FINISH);

    // operands are never overwritten by the engine
    wr_c_only: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && mem_req.we) |-> (mem_req.addr >= `CMAT_C_BASE));

endmodule

`default_nettype wire

// File: logic/cmat_top.sv
`timescale 1ns/10ps
`default_nettype none

module cmat_top (
    input  logic               clk,
    input  logic               rst,
    input  cmat_pkg::apb_req_t apb,
    output cmat_pkg::apb_rsp_t apb_out,
    output logic               irq
);

    import cmat_pkg::*;

    // two requesters meet at the arbiter in front of the one store
    mem_req_t host_req;
    mem_req_t eng_req;
    mem_req_t store_req;
    mem_rsp_t host_rsp;
    mem_rsp_t eng_rsp;
    cplx_t    store_rdata;
    logic     host_gnt;
    logic     eng_gnt;
    logic     start;
    logic     busy;
    logic     finish;

    cmat_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb     (apb),
        .apb_out (apb_out),
        .mem_req (host_req),
        .mem_gnt (host_gnt),
        .mem_rsp (host_rsp),
        .start   (start),
        .busy    (busy),
        .finish  (finish),
        .irq     (irq)
    );

    mat_mult_complex u_engine (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .busy    (busy),
        .finish  (finish),
        .mem_req (eng_req),
        .mem_gnt (eng_gnt),
        .mem_rsp (eng_rsp)
    );

    cmat_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .eng_req     (eng_req),
        .host_gnt    (host_gnt),
        .eng_gnt     (eng_gnt),
        .host_rsp    (host_rsp),
        .eng_rsp     (eng_rsp),
        .store_req   (store_req),
        .store_rdata (store_rdata)
    );

    cmat_store u_store (
        .clk   (clk),
        .req   (store_req),
        .rdata (store_rdata)
    );

endmodule

`default_nettype wire

// File: verification/cmat_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmat_consts.svh"

module cmat_tb;

    import cmat_pkg::*;

    typedef enum logic [1:0] {K_IDENTITY, K_RANDOM, K_STRESS} test_kind_t;

    // one table row, with the job to run, the fill seed and the probe access at the end
    typedef struct packed {
        test_kind_t kind;
        logic [7:0] seed_ofs;
        logic [7:0] probe_addr;
        logic       exp_err;
    } test_row_t;

    localparam int NUM_TESTS  = 4;
    localparam int XFER_LIMIT = 50;
    // a full job takes a few hundred cycles, so this leaves a wide margin
    localparam int JOB_LIMIT  = 5000;

    logic     clk;
    logic     rst;
    apb_req_t apb;
    apb_rsp_t apb_out;
    logic     irq;

    test_row_t tests [0:NUM_TESTS-1];
    // host copies of the operands, used for read-back and for the golden model
    cplx_t     a_mat [0:`CMAT_WORDS-1];
    cplx_t     b_mat [0:`CMAT_WORDS-1];
    integer    seed;
    int        checks;
    int        errors;
    int        failed_tests;

    cmat_top DUT (
        .clk     (clk),
        .rst     (rst),
        .apb     (apb),
        .apb_out (apb_out),
        .irq     (irq)
    );

    always #2 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR t=%0t signal %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one APB transfer, setup then access, held until pready
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int   cnt;
        logic done;
        cnt   = 0;
        done  = 1'b0;
        rdata = '0;
        err   = 1'b0;
        @(posedge clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= wr;
        apb.paddr   <= addr;
        apb.pwdata  <= wdata;
        @(posedge clk);
        apb.penable <= 1'b1;
        // response is sampled mid-cycle where the combinational pready has settled
        while (!done && cnt < XFER_LIMIT) begin
            @(negedge clk);
            if (apb_out.pready) begin
                done  = 1'b1;
                rdata = apb_out.prdata;
                err   = apb_out.pslverr;
            end else begin
                cnt++;
            end
        end
        if (!done) begin
            errors++;
            $display("APB transfer to address %h never completed, pready stayed low", addr);
        end
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic wait_irq();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!irq && cnt < JOB_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!irq) begin
            errors++;
            $display("engine never raised irq after the start write");
        end
    endtask

    // byte address of a word inside one of the matrix regions
    function automatic logic [7:0] word_addr(input int base, input int idx);
        return 8'((base + idx) * 4);
    endfunction

    // reference element C[r][c] with 32-bit sums, keeping the low half of each
    function automatic cplx_t golden_elem(input int r, input int c);
        logic signed [31:0] sum_re;
        logic signed [31:0] sum_im;
        logic signed [15:0] ar;
        logic signed [15:0] ai;
        logic signed [15:0] br;
        logic signed [15:0] bi;
        int                 k;
        sum_re = 0;
        sum_im = 0;
        for (k = 0; k < `CMAT_N; k++) begin
            ar = a_mat[r * `CMAT_N + k][31:16];
            ai = a_mat[r * `CMAT_N + k][15:0];
            br = b_mat[k * `CMAT_N + c][31:16];
            bi = b_mat[k * `CMAT_N + c][15:0];
            sum_re = sum_re + ar * br - ai * bi;
            sum_im = sum_im + ar * bi + ai * br;
        end
        return {sum_re[15:0], sum_im[15:0]};
    endfunction

    task automatic fill_operands(input test_row_t row);
        int idx;
        seed = 32'h630d + row.seed_ofs;
        for (idx = 0; idx < `CMAT_WORDS; idx++) begin
            a_mat[idx] = $random(seed);
            if (row.kind == K_IDENTITY) begin
                // one on the diagonal is real 1, imaginary 0
                b_mat[idx] = (idx / `CMAT_N == idx % `CMAT_N) ? 32'h0001_0000 : 32'h0;
            end else begin
                b_mat[idx] = $random(seed);
            end
        end
    endtask

    task automatic run_test(input int num, input test_row_t row);
        int          idx;
        int          errs_before;
        logic [31:0] data;
        logic        err;
        cplx_t       exp;
        errs_before = errors;
        fill_operands(row);
        for (idx = 0; idx < `CMAT_WORDS; idx++) begin
            apb_write(word_addr(`CMAT_A_BASE, idx), a_mat[idx], err);
        end
        for (idx = 0; idx < `CMAT_WORDS; idx++) begin
            apb_write(word_addr(`CMAT_B_BASE, idx), b_mat[idx], err);
        end
        // both regions must hold exactly what was written
        for (idx = 0; idx < `CMAT_WORDS; idx++) begin
            apb_read(word_addr(`CMAT_A_BASE, idx), data, err);
            check_val("a_word", data, a_mat[idx]);
        end
        for (idx = 0; idx < `CMAT_WORDS; idx++) begin
            apb_read(word_addr(`CMAT_B_BASE, idx), data, err);
            check_val("b_word", data, b_mat[idx]);
        end
        apb_write(8'(`CMAT_CTRL_OFS), 32'h1, err);
        // right after start the engine is busy and the old done flag is gone
        apb_read(8'(`CMAT_STAT_OFS), data, err);
        check_val("status", data, 32'h1);
        @(negedge clk);
        check_val("irq", {31'd0, irq}, 32'h0);
        if (row.kind == K_STRESS) begin
            // host reads compete with the engine for the store
            for (idx = 0; idx < `CMAT_WORDS; idx++) begin
                apb_read(word_addr(`CMAT_A_BASE, idx), data, err);
                check_val("a_word_busy", data, a_mat[idx]);
            end
            apb_read(8'(`CMAT_STAT_OFS), data, err);
            check_val("status_busy", {31'd0, data[0]}, 32'h1);
            // a second start during the job must be dropped
            apb_write(8'(`CMAT_CTRL_OFS), 32'h1, err);
        end
        wait_irq();
        apb_read(8'(`CMAT_STAT_OFS), data, err);
        check_val("status", data, 32'h2);
        if (row.kind == K_STRESS) begin
            // no second job may follow, so irq stays up and busy stays low
            repeat (32) @(negedge clk);
            check_val("irq", {31'd0, irq}, 32'h1);
            apb_read(8'(`CMAT_STAT_OFS), data, err);
            check_val("status", data, 32'h2);
        end
        for (idx = 0; idx < `CMAT_WORDS; idx++) begin
            apb_read(word_addr(`CMAT_C_BASE, idx), data, err);
            if (row.kind == K_IDENTITY) begin
                exp = a_mat[idx];
            end else begin
                exp = golden_elem(idx / `CMAT_N, idx % `CMAT_N);
            end
            check_val("c_word", data, exp);
        end
        apb_read(row.probe_addr, data, err);
        check_val("pslverr", {31'd0, err}, {31'd0, row.exp_err});
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, row.kind.name());
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", num, row.kind.name(),
                     errors - errs_before);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        apb          = '0;
        checks       = 0;
        errors       = 0;
        failed_tests = 0;
        // the probe column walks the register window and the error space behind it
        tests[0] = '{kind: K_IDENTITY, seed_ofs: 8'd0, probe_addr: 8'(`CMAT_STAT_OFS),
                     exp_err: 1'b0};
        tests[1] = '{kind: K_RANDOM, seed_ofs: 8'd1, probe_addr: 8'hfc, exp_err: 1'b1};
        tests[2] = '{kind: K_STRESS, seed_ofs: 8'd2, probe_addr: 8'hc8, exp_err: 1'b1};
        tests[3] = '{kind: K_RANDOM, seed_ofs: 8'd3, probe_addr: 8'(`CMAT_CTRL_OFS),
                     exp_err: 1'b0};
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("irq", {31'd0, irq}, 32'h0);
        check_val("pready", {31'd0, apb_out.pready}, 32'h0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t, tests[t]);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cmat.f
+incdir+logic
logic/cmat_pkg.sv
logic/cmat_store.sv
logic/cmat_arbiter.sv
logic/cmat_apb_regs.sv
logic/vec_mult_acc.sv
logic/mat_mult_complex.sv
logic/cmat_top.sv
verification/cmat_tb.sv

// File: Bender.yml
package:
  name: cmat

sources:
  - include_dirs:
      - logic
    files:
      - logic/cmat_pkg.sv
      - logic/cmat_store.sv
      - logic/cmat_arbiter.sv
      - logic/cmat_apb_regs.sv
      - logic/vec_mult_acc.sv
      - logic/mat_mult_complex.sv
      - logic/cmat_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/cmat_tb.sv
